/* filelist.f */
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/apb_host_port.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/mem_wb_unit.sv
hw/proc_top.sv
tb/proc_assertions.sv
tb/proc_tb.sv

/* Bender.yml */
package:
  name: proc_core

sources:
  - hw/isa_pkg.sv
  - hw/pipe_pkg.sv
  - hw/apb_host_port.sv
  - hw/fetch_unit.sv
  - hw/decode_unit.sv
  - hw/execute_unit.sv
  - hw/mem_wb_unit.sv
  - hw/proc_top.sv
  - target: test
    files:
      - tb/proc_assertions.sv
      - tb/proc_tb.sv

/* tb/proc_tb.sv */
`default_nettype none

module proc_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import isa_pkg::*;
   import pipe_pkg::*;

   localparam int n_tests    = 5;
   localparam int max_len    = 20;
   localparam int n_data     = 8;
   localparam int pad_len    = 4;
   localparam int clk_period = 20;

   logic              clk;
   logic              rst_n;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [11:0]       paddr;
   logic [data_w-1:0] pwdata;
   logic [data_w-1:0] prdata;
   logic              pready;
   logic              pslverr;
   logic              halted;
   retire_t           retire;

   // Stimulus table, one row per test
   string             test_name [n_tests];
   int                prog_len [n_tests];
   logic [data_w-1:0] prog [n_tests][max_len];
   logic [data_w-1:0] init_data [n_tests][n_data];

   // Expected writes and memory from the ISA model
   reg_idx_t          exp_idx [$];
   logic [data_w-1:0] exp_val [$];
   logic [data_w-1:0] exp_mem [256];

   // Writes seen on the retire port
   reg_idx_t          got_idx [$];
   logic [data_w-1:0] got_val [$];

   int seed = 32'hb9f;
   int errors = 0;
   int checks = 0;
   int test_errors = 0;
   int failed_tests = 0;
   bit table_ready = 0;

   proc_top #(.imem_depth(256), .dmem_depth(256)) dut (
      .clk(clk), .rst_n(rst_n),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .retire(retire), .halted(halted)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // Retire valid lasts one full cycle, so the falling edge sees it once
   always @(negedge clk) begin
      if (rst_n && retire.valid) begin
         got_idx.push_back(retire.idx);
         got_val.push_back(retire.data);
      end
   end

   // Budget of 20 cycles per program word
   initial begin
      int budget;
      budget = 0;
      wait (table_ready);
      for (int t = 0; t < n_tests; t++) begin
         budget += prog_len[t];
      end
      #(budget * 20 * clk_period);
      $display("Watchdog expired after %0d cycles, the core never halted", budget * 20);
      $display(">>> FAIL");
      $finish;
   end

   function automatic logic [data_w-1:0] encode_r(opcode_e op, reg_idx_t rd, reg_idx_t rs,
                                                  reg_idx_t rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic logic [data_w-1:0] encode_i(opcode_e op, reg_idx_t rd, reg_idx_t rs,
                                                  int imm);
      return {op, rd, rs, imm[5:0]};
   endfunction

   task automatic add_instr(input int t, input logic [data_w-1:0] w);
      prog[t][prog_len[t]] = w;
      prog_len[t]++;
   endtask

   task automatic build_table();
      int rnd;
      for (int t = 0; t < n_tests; t++) begin
         prog_len[t] = 0;
         for (int k = 0; k < n_data; k++) begin
            rnd = $random(seed);
            init_data[t][k] = rnd[15:0];
         end
      end
      // ALU ops on two random words from memory
      test_name[0] = "alu_random";
      add_instr(0, encode_i(op_ld, 1, 0, 0));
      add_instr(0, encode_i(op_ld, 2, 0, 1));
      add_instr(0, nop_word);
      add_instr(0, encode_r(op_add, 3, 1, 2));
      add_instr(0, encode_r(op_sub, 4, 1, 2));
      add_instr(0, encode_r(op_and, 5, 3, 4));
      add_instr(0, encode_r(op_xor, 6, 1, 2));
      add_instr(0, encode_i(op_addi, 7, 6, -5));
      add_instr(0, encode_i(op_halt, 0, 0, 0));
      // Every source one to three slots behind its producer
      test_name[1] = "forward_chain";
      add_instr(1, encode_i(op_addi, 1, 0, 7));
      add_instr(1, encode_i(op_addi, 2, 1, 3));
      add_instr(1, encode_r(op_add, 3, 2, 1));
      add_instr(1, encode_r(op_sub, 4, 3, 1));
      add_instr(1, encode_r(op_xor, 5, 4, 2));
      add_instr(1, encode_i(op_addi, 5, 5, -1));
      add_instr(1, encode_r(op_and, 6, 5, 3));
      add_instr(1, encode_i(op_halt, 0, 0, 0));
      // Use right after load, on either operand
      test_name[2] = "load_use";
      add_instr(2, encode_i(op_ld, 1, 0, 2));
      add_instr(2, encode_i(op_addi, 2, 1, 1));
      add_instr(2, encode_i(op_ld, 3, 0, 3));
      add_instr(2, encode_r(op_add, 4, 3, 2));
      add_instr(2, encode_i(op_ld, 5, 0, 4));
      add_instr(2, encode_r(op_sub, 6, 2, 5));
      add_instr(2, encode_i(op_halt, 0, 0, 0));
      // Count-down loop, then taken and not-taken skips
      test_name[3] = "branch_loops";
      add_instr(3, encode_i(op_addi, 1, 0, 3));
      add_instr(3, encode_i(op_addi, 2, 0, 0));
      add_instr(3, encode_r(op_add, 2, 2, 1));
      add_instr(3, encode_i(op_addi, 1, 1, -1));
      add_instr(3, encode_i(op_bnez, 0, 1, -3));
      add_instr(3, encode_i(op_addi, 3, 0, 9));
      add_instr(3, encode_i(op_beqz, 0, 1, 1));
      add_instr(3, encode_i(op_addi, 4, 0, 5));
      add_instr(3, encode_i(op_beqz, 0, 2, 2));
      add_instr(3, encode_i(op_addi, 5, 2, 1));
      add_instr(3, encode_i(op_bnez, 0, 0, 3));
      add_instr(3, encode_r(op_xor, 6, 2, 5));
      add_instr(3, encode_i(op_halt, 0, 0, 0));
      // Stores, reload, and a store just before halt
      test_name[4] = "store_halt";
      add_instr(4, encode_i(op_ld, 1, 0, 5));
      add_instr(4, encode_i(op_addi, 2, 1, 4));
      add_instr(4, encode_i(op_st, 2, 0, 6));
      add_instr(4, encode_i(op_addi, 3, 0, 2));
      add_instr(4, encode_i(op_st, 1, 3, 5));
      add_instr(4, encode_i(op_ld, 4, 0, 6));
      add_instr(4, encode_i(op_st, 4, 0, 0));
      add_instr(4, encode_i(op_halt, 0, 0, 0));
      table_ready = 1;
   endtask

   // Instruction-level interpreter, one instruction per step
   task automatic run_model(input int t);
      logic [data_w-1:0] regs [8];
      logic [data_w-1:0] w;
      logic [data_w-1:0] a;
      logic [data_w-1:0] b;
      logic [data_w-1:0] imm;
      logic [data_w-1:0] ea;
      logic [data_w-1:0] val;
      logic [data_w-1:0] pc;
      opcode_e           op;
      reg_idx_t          rd;
      logic              wr;
      bit                done;
      int                steps;
      exp_idx.delete();
      exp_val.delete();
      for (int k = 0; k < 8; k++) begin
         regs[k] = '0;
      end
      for (int k = 0; k < 256; k++) begin
         exp_mem[k] = (k < n_data) ? init_data[t][k] : '0;
      end
      pc = '0;
      done = 0;
      steps = 0;
      while (!done) begin
         if (steps > 500 || pc >= prog_len[t]) begin
            $display("Reference model ran past the end of program %s", test_name[t]);
            errors++;
            test_errors++;
            break;
         end
         w   = prog[t][pc];
         op  = opcode_e'(w[15:12]);
         rd  = w[11:9];
         a   = regs[w[8:6]];
         b   = regs[w[5:3]];
         imm = {{10{w[5]}}, w[5:0]};
         ea  = a + imm;
         wr  = 1'b0;
         val = '0;
         pc  = pc + 1;
         case (op)
            op_halt: done = 1;
            op_add: begin
               val = a + b;
               wr  = 1'b1;
            end
            op_sub: begin
               val = a - b;
               wr  = 1'b1;
            end
            op_and: begin
               val = a & b;
               wr  = 1'b1;
            end
            op_xor: begin
               val = a ^ b;
               wr  = 1'b1;
            end
            op_addi: begin
               val = ea;
               wr  = 1'b1;
            end
            op_ld: begin
               val = exp_mem[ea[7:0]];
               wr  = 1'b1;
            end
            op_st:   exp_mem[ea[7:0]] = regs[rd];
            op_beqz: if (a == '0) pc = pc + imm;
            op_bnez: if (a != '0) pc = pc + imm;
            default: ;
         endcase
         // r0 stays zero and never retires
         if (wr && rd != '0) begin
            regs[rd] = val;
            exp_idx.push_back(rd);
            exp_val.push_back(val);
         end
         steps++;
      end
   endtask

   task automatic apb_write(input logic [11:0] addr, input logic [data_w-1:0] data);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);
      // Zero wait states, no error response
      compare_value("pready", 32'h1, pready);
      compare_value("pslverr", 32'h0, pslverr);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [11:0] addr, output logic [data_w-1:0] data);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);
      // Address still held, read data settled
      data    = prdata;
      compare_value("pready", 32'h1, pready);
      compare_value("pslverr", 32'h0, pslverr);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected,
                  actual);
         errors++;
         test_errors++;
      end
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst_n = 1'b0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
   endtask

   task automatic run_test(input int t);
      logic [data_w-1:0] rd_data;
      int                n;
      test_errors = 0;
      run_model(t);
      apply_reset();
      // Idle core after reset
      apb_read(12'h000, rd_data);
      compare_value("ctrl after reset", 32'h0, rd_data);
      compare_value("halted", 32'h0, halted);
      compare_value("retire.valid", 32'h0, retire.valid);
      // Program plus a NOP tail for the fetches past HALT
      for (int k = 0; k < prog_len[t] + pad_len; k++) begin
         apb_write(12'h400 + k, (k < prog_len[t]) ? prog[t][k] : nop_word);
      end
      for (int k = 0; k < n_data; k++) begin
         apb_write(12'h800 + k, init_data[t][k]);
      end
      got_idx.delete();
      got_val.delete();
      apb_write(12'h000, 16'h0001);
      while (halted !== 1'b1) @(negedge clk);
      // Halted set, run cleared
      apb_read(12'h000, rd_data);
      compare_value("ctrl after halt", 32'h2, rd_data);
      compare_value("retire count", exp_idx.size(), got_idx.size());
      n = (got_idx.size() < exp_idx.size()) ? got_idx.size() : exp_idx.size();
      for (int k = 0; k < n; k++) begin
         compare_value($sformatf("retire[%0d].idx", k), exp_idx[k], got_idx[k]);
         compare_value($sformatf("retire[%0d].data", k), exp_val[k], got_val[k]);
      end
      for (int k = 0; k < n_data; k++) begin
         apb_read(12'h800 + k, rd_data);
         compare_value($sformatf("dmem[%0d]", k), exp_mem[k], rd_data);
      end
      if (test_errors == 0) begin
         $display("test %0d %s ok, %0d writes retired", t, test_name[t], got_idx.size());
      end else begin
         $display("test %0d %s failed, %0d errors", t, test_name[t], test_errors);
         failed_tests++;
      end
   endtask

   initial begin
      rst_n   = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      build_table();
      for (int t = 0; t < n_tests; t++) begin
         run_test(t);
      end
      $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
               n_tests, failed_tests, checks, errors, dut.u_assertions.fail_count);
      if (errors == 0 && dut.u_assertions.fail_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb/proc_assertions.sv */
`default_nettype none

module proc_assertions (
   input logic              clk,
   input logic              rst_n,
   input logic              psel,
   input logic              penable,
   input logic              halt,
   input logic              run,
   input logic              stall,
   input pipe_pkg::retire_t retire
);

   timeunit 1ns;
   timeprecision 100ps;

   // Read by the testbench at the end of the run
   int fail_count = 0;

   // Setup phase always moves to access
   penable_follows_psel: assert property (@(posedge clk) disable iff (!rst_n)
      (psel && !penable) |=> (psel && penable))
      else begin
         $error("APB setup phase not followed by access phase");
         fail_count++;
      end

   // Halt stops the core one cycle later
   run_clears_on_halt: assert property (@(posedge clk) disable iff (!rst_n)
      halt |=> !run)
      else begin
         $error("run still high after halt");
         fail_count++;
      end

   // Load-use bubble is a single slot
   stall_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      stall |=> !stall)
      else begin
         $error("stall held for more than one cycle");
         fail_count++;
      end

   // Nothing retires while stopped
   no_retire_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
      !run |-> !retire.valid)
      else begin
         $error("retire valid while run is low");
         fail_count++;
      end

endmodule

bind proc_top proc_assertions u_assertions (
   .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable),
   .halt(halt), .run(run), .stall(stall), .retire(retire)
);

`default_nettype wire

/* hw/proc_top.sv */
`default_nettype none

module proc_top #(
   parameter int imem_depth = 256,
   parameter int dmem_depth = 256
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         psel,
   input  logic                         penable,
   input  logic                         pwrite,
   input  logic [11:0]                  paddr,
   input  logic [isa_pkg::data_w-1:0]   pwdata,
   output logic [isa_pkg::data_w-1:0]   prdata,
   output logic                         pready,
   output logic                         pslverr,
   output pipe_pkg::retire_t            retire,
   output logic                         halted
);

   import isa_pkg::*;
   import pipe_pkg::*;

   // Control
   logic run;
   logic halt;
   logic stall;
   logic branch_taken;
   logic [data_w-1:0] branch_target;

   // Host access to the memories
   logic                          imem_we;
   logic [$clog2(imem_depth)-1:0] imem_addr;
   logic [data_w-1:0]             imem_wdata;
   logic                          dmem_req;
   logic                          dmem_we;
   logic [$clog2(dmem_depth)-1:0] dmem_addr;
   logic [data_w-1:0]             dmem_wdata;
   logic [data_w-1:0]             dmem_rdata;

   // Stage registers and forwarding
   if_id_t            if_id;
   id_ex_t            id_ex;
   ex_mem_t           ex_mem;
   logic [data_w-1:0] ex_result;
   logic [data_w-1:0] mem_result;

   apb_host_port #(.imem_depth(imem_depth), .dmem_depth(dmem_depth)) u_apb (
      .clk(clk), .rst_n(rst_n),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .halt(halt), .run(run), .halted(halted),
      .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
      .dmem_req(dmem_req), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
      .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata)
   );

   fetch_unit #(.imem_depth(imem_depth)) u_fetch (
      .clk(clk), .rst_n(rst_n), .run(run), .stall(stall),
      .branch_taken(branch_taken), .branch_target(branch_target),
      .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
      .if_id(if_id)
   );

   // Write-back record doubles as the register-file write
   decode_unit u_decode (
      .clk(clk), .rst_n(rst_n), .run(run), .if_id(if_id),
      .branch_taken(branch_taken), .ex_result(ex_result),
      .mem_fwd(ex_mem), .mem_result(mem_result), .wb(retire),
      .stall(stall), .id_ex(id_ex)
   );

   execute_unit u_execute (
      .clk(clk), .rst_n(rst_n), .run(run), .id_ex(id_ex),
      .ex_result(ex_result), .branch_taken(branch_taken),
      .branch_target(branch_target), .ex_mem(ex_mem)
   );

   mem_wb_unit #(.dmem_depth(dmem_depth)) u_mem_wb (
      .clk(clk), .rst_n(rst_n), .run(run), .ex_mem(ex_mem),
      .dmem_req(dmem_req), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
      .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
      .mem_result(mem_result), .halt(halt), .retire(retire)
   );

endmodule

`default_nettype wire

/* hw/mem_wb_unit.sv */
`default_nettype none

module mem_wb_unit #(
   parameter int dmem_depth = 256
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                run,
   input  pipe_pkg::ex_mem_t                   ex_mem,
   input  logic                                dmem_req,
   input  logic                                dmem_we,
   input  logic [$clog2(dmem_depth)-1:0]       dmem_addr,
   input  logic [isa_pkg::data_w-1:0]          dmem_wdata,
   output logic [isa_pkg::data_w-1:0]          dmem_rdata,
   output logic [isa_pkg::data_w-1:0]          mem_result,
   output logic                                halt,
   output pipe_pkg::retire_t                   retire
);

   import isa_pkg::*;
   import pipe_pkg::*;

   localparam int da_w = $clog2(dmem_depth);

   logic [data_w-1:0] dmem [dmem_depth];
   opcode_e           op;
   logic [da_w-1:0]   pipe_addr;

   assign op        = ex_mem.instr.r.opcode;
   assign pipe_addr = ex_mem.result[da_w-1:0];

   // Pipeline owns the memory while running, host otherwise
   always_ff @(posedge clk) begin
      if (run) begin
         if (op == op_st) begin
            dmem[pipe_addr] <= ex_mem.st_data;
         end
      end else if (dmem_req && dmem_we) begin
         dmem[dmem_addr] <= dmem_wdata;
      end
   end

   // Single-cycle reads on both sides
   assign mem_result = dmem[pipe_addr];
   assign dmem_rdata = dmem[dmem_addr];

   // Everything older has left the memory stage
   assign halt = run && (op == op_halt);

   // Write-back select into the retire record
   always_ff @(posedge clk) begin
      if (!rst_n || !run) begin
         retire <= '0;
      end else begin
         retire.valid <= ex_mem.wr_en;
         retire.idx   <= ex_mem.wr_idx;
         retire.data  <= (op == op_ld) ? mem_result : ex_mem.result;
      end
   end

endmodule

`default_nettype wire

/* hw/execute_unit.sv */
`default_nettype none

module execute_unit (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         run,
   input  pipe_pkg::id_ex_t             id_ex,
   output logic [isa_pkg::data_w-1:0]   ex_result,
   output logic                         branch_taken,
   output logic [isa_pkg::data_w-1:0]   branch_target,
   output pipe_pkg::ex_mem_t            ex_mem
);

   import isa_pkg::*;
   import pipe_pkg::*;

   opcode_e           op;
   logic [5:0]        imm;
   logic [data_w-1:0] imm_ext;
   logic              is_r;
   logic [data_w-1:0] alu_b;

   assign op  = id_ex.instr.r.opcode;
   assign imm = id_ex.instr.i.imm;

   // Sign extend the 6-bit field
   assign imm_ext = {{(data_w - 6){imm[5]}}, imm};

   // Register ops take rt, the rest the immediate
   assign is_r  = (op == op_add) || (op == op_sub) || (op == op_and) || (op == op_xor);
   assign alu_b = is_r ? id_ex.op_b : imm_ext;

   always_comb begin
      case (op)
         op_add, op_addi, op_ld, op_st: ex_result = id_ex.op_a + alu_b;
         op_sub:  ex_result = id_ex.op_a - alu_b;
         op_and:  ex_result = id_ex.op_a & alu_b;
         op_xor:  ex_result = id_ex.op_a ^ alu_b;
         default: ex_result = '0;
      endcase
   end

   // Branch on rs compared against zero
   assign branch_taken = ((op == op_beqz) && (id_ex.op_a == '0)) ||
                         ((op == op_bnez) && (id_ex.op_a != '0));

   // Relative to the next instruction
   assign branch_target = id_ex.pc_inc + imm_ext;

   always_ff @(posedge clk) begin
      if (!rst_n || !run) begin
         ex_mem       <= '0;
         ex_mem.instr <= nop_word;
      end else begin
         ex_mem.instr   <= id_ex.instr;
         ex_mem.result  <= ex_result;
         // Forwarded rd value for stores
         ex_mem.st_data <= id_ex.op_b;
         ex_mem.wr_idx  <= id_ex.wr_idx;
         ex_mem.wr_en   <= id_ex.wr_en;
      end
   end

endmodule

`default_nettype wire

/* hw/decode_unit.sv */
`default_nettype none

module decode_unit (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         run,
   input  pipe_pkg::if_id_t             if_id,
   input  logic                         branch_taken,
   input  logic [isa_pkg::data_w-1:0]   ex_result,
   input  pipe_pkg::ex_mem_t            mem_fwd,
   input  logic [isa_pkg::data_w-1:0]   mem_result,
   input  pipe_pkg::retire_t            wb,
   output logic                         stall,
   output pipe_pkg::id_ex_t             id_ex
);

   import isa_pkg::*;
   import pipe_pkg::*;

   logic [data_w-1:0] rf [8];
   opcode_e           op;
   reg_idx_t          rs;
   reg_idx_t          src2;
   logic              uses_a;
   logic              uses_b;
   logic              writes;
   logic              ex_is_ld;
   logic              mem_is_ld;
   logic [data_w-1:0] rf_a;
   logic [data_w-1:0] rf_b;
   id_ex_t            id_ex_d;

   // Same word seen in both formats
   assign op   = if_id.instr.r.opcode;
   assign rs   = if_id.instr.r.rs;
   // Store reads its data from rd
   assign src2 = (op == op_st) ? if_id.instr.i.rd : if_id.instr.r.rt;

   assign uses_a = (op != op_halt) && (op != op_nop);
   assign uses_b = (op == op_add) || (op == op_sub) || (op == op_and) ||
                   (op == op_xor) || (op == op_st);
   assign writes = (op == op_add) || (op == op_sub) || (op == op_and) ||
                   (op == op_xor) || (op == op_addi) || (op == op_ld);

   assign ex_is_ld  = (id_ex.instr.r.opcode == op_ld);
   assign mem_is_ld = (mem_fwd.instr.r.opcode == op_ld);

   // Register file, written from write-back
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int k = 0; k < 8; k++) begin
            rf[k] <= '0;
         end
      end else if (wb.valid) begin
         rf[wb.idx] <= wb.data;
      end
   end

   // r0 is hardwired
   assign rf_a = (rs == '0) ? '0 : rf[rs];
   assign rf_b = (src2 == '0) ? '0 : rf[src2];

   // Youngest producer wins
   function automatic logic [data_w-1:0] fwd(input reg_idx_t idx,
                                             input logic [data_w-1:0] rf_val);
      if (id_ex.wr_en && (id_ex.wr_idx == idx) && !ex_is_ld) begin
         return ex_result;
      end
      if (mem_fwd.wr_en && (mem_fwd.wr_idx == idx)) begin
         // Load data only exists in the memory stage
         return mem_is_ld ? mem_result : mem_fwd.result;
      end
      if (wb.valid && (wb.idx == idx)) begin
         return wb.data;
      end
      return rf_val;
   endfunction

   // Load in execute feeding this instruction
   assign stall = ex_is_ld && id_ex.wr_en &&
                  ((uses_a && (id_ex.wr_idx == rs)) ||
                   (uses_b && (id_ex.wr_idx == src2)));

   always_comb begin
      id_ex_d.instr  = if_id.instr;
      id_ex_d.pc_inc = if_id.pc_inc;
      id_ex_d.op_a   = fwd(rs, rf_a);
      id_ex_d.op_b   = fwd(src2, rf_b);
      id_ex_d.wr_idx = if_id.instr.i.rd;
      // Writes to r0 are dropped here
      id_ex_d.wr_en  = writes && (if_id.instr.i.rd != '0);
   end

   // Bubble on stall, flush on branch
   always_ff @(posedge clk) begin
      if (!rst_n || !run || stall || branch_taken) begin
         id_ex       <= '0;
         id_ex.instr <= nop_word;
      end else begin
         id_ex <= id_ex_d;
      end
   end

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
`default_nettype none

module fetch_unit #(
   parameter int imem_depth = 256
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                run,
   input  logic                                stall,
   input  logic                                branch_taken,
   input  logic [isa_pkg::data_w-1:0]          branch_target,
   input  logic                                imem_we,
   input  logic [$clog2(imem_depth)-1:0]       imem_addr,
   input  logic [isa_pkg::data_w-1:0]          imem_wdata,
   output pipe_pkg::if_id_t                    if_id
);

   import isa_pkg::*;
   import pipe_pkg::*;

   localparam int ia_w = $clog2(imem_depth);

   logic [data_w-1:0] imem [imem_depth];
   logic [data_w-1:0] pc;
   logic [data_w-1:0] pc_inc;
   logic [data_w-1:0] next_pc;

   // Host loads the program while stopped
   always_ff @(posedge clk) begin
      if (imem_we) begin
         imem[imem_addr] <= imem_wdata;
      end
   end

   // Word addressed
   assign pc_inc = pc + 1'b1;

   // Branch redirect first, then hold on stall
   always_comb begin
      if (branch_taken) begin
         next_pc = branch_target;
      end else if (stall) begin
         next_pc = pc;
      end else begin
         next_pc = pc_inc;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n || !run) begin
         // Start from zero when run rises
         pc           <= '0;
         if_id.instr  <= nop_word;
         if_id.pc_inc <= '0;
      end else begin
         pc <= next_pc;
         if (branch_taken) begin
            // Younger fetch is on the wrong path
            if_id.instr <= nop_word;
         end else if (!stall) begin
            if_id.instr  <= imem[pc[ia_w-1:0]];
            if_id.pc_inc <= pc_inc;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/apb_host_port.sv */
`default_nettype none

module apb_host_port #(
   parameter int imem_depth = 256,
   parameter int dmem_depth = 256
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [11:0]                         paddr,
   input  logic [isa_pkg::data_w-1:0]          pwdata,
   output logic [isa_pkg::data_w-1:0]          prdata,
   output logic                                pready,
   output logic                                pslverr,
   input  logic                                halt,
   output logic                                run,
   output logic                                halted,
   output logic                                imem_we,
   output logic [$clog2(imem_depth)-1:0]       imem_addr,
   output logic [isa_pkg::data_w-1:0]          imem_wdata,
   output logic                                dmem_req,
   output logic                                dmem_we,
   output logic [$clog2(dmem_depth)-1:0]       dmem_addr,
   output logic [isa_pkg::data_w-1:0]          dmem_wdata,
   input  logic [isa_pkg::data_w-1:0]          dmem_rdata
);

   // Target select in paddr[11:10]
   localparam logic [1:0] sel_ctrl = 2'b00;
   localparam logic [1:0] sel_imem = 2'b01;
   localparam logic [1:0] sel_dmem = 2'b10;

   logic       access;
   logic [1:0] target;
   logic       ctrl_wr;

   // Access phase of a transfer
   assign access  = psel && penable;
   assign target  = paddr[11:10];
   assign ctrl_wr = access && pwrite && (target == sel_ctrl);

   // Zero wait states, never an error
   assign pready  = 1'b1;
   assign pslverr = 1'b0;

   // Memories only reachable while the core is stopped
   assign imem_we    = access && pwrite && !run && (target == sel_imem);
   assign imem_addr  = paddr[$clog2(imem_depth)-1:0];
   assign imem_wdata = pwdata;

   assign dmem_req   = access && !run && (target == sel_dmem);
   assign dmem_we    = pwrite;
   assign dmem_addr  = paddr[$clog2(dmem_depth)-1:0];
   assign dmem_wdata = pwdata;

   // Halt wins over a host write in the same cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         run    <= 1'b0;
         halted <= 1'b0;
      end else if (halt) begin
         run    <= 1'b0;
         halted <= 1'b1;
      end else if (ctrl_wr) begin
         run <= pwdata[0];
         // Restart clears the status
         if (pwdata[0]) begin
            halted <= 1'b0;
         end
      end
   end

   // Read mux
   always_comb begin
      prdata = '0;
      case (target)
         sel_ctrl: prdata[1:0] = {halted, run};
         sel_dmem: prdata = dmem_rdata;
         default:  prdata = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

   // Fetch to decode
   typedef struct packed {
      isa_pkg::instr_u                 instr;
      logic [isa_pkg::data_w-1:0]      pc_inc;
   } if_id_t;

   // Decode to execute, operands already forwarded
   typedef struct packed {
      isa_pkg::instr_u                 instr;
      logic [isa_pkg::data_w-1:0]      pc_inc;
      logic [isa_pkg::data_w-1:0]      op_a;
      logic [isa_pkg::data_w-1:0]      op_b;
      isa_pkg::reg_idx_t               wr_idx;
      logic                            wr_en;
   } id_ex_t;

   // Execute to memory
   typedef struct packed {
      isa_pkg::instr_u                 instr;
      logic [isa_pkg::data_w-1:0]      result;
      logic [isa_pkg::data_w-1:0]      st_data;
      isa_pkg::reg_idx_t               wr_idx;
      logic                            wr_en;
   } ex_mem_t;

   // Write-back record, also the retire port
   typedef struct packed {
      logic                            valid;
      isa_pkg::reg_idx_t               idx;
      logic [isa_pkg::data_w-1:0]      data;
   } retire_t;

endpackage

`default_nettype wire

/* hw/isa_pkg.sv */
`default_nettype none

package isa_pkg;

   // Data path and instruction word width
   localparam int data_w = 16;

   // Eight registers, r0 reads as zero
   typedef logic [2:0] reg_idx_t;

   typedef enum logic [3:0] {
      op_halt = 4'd0,
      op_nop  = 4'd1,
      op_add  = 4'd2,
      op_sub  = 4'd3,
      op_and  = 4'd4,
      op_xor  = 4'd5,
      op_addi = 4'd6,
      op_ld   = 4'd7,
      op_st   = 4'd8,
      op_beqz = 4'd9,
      op_bnez = 4'd10
   } opcode_e;

   // Register format, rd = rs op rt
   typedef struct packed {
      opcode_e    opcode;
      reg_idx_t   rd;
      reg_idx_t   rs;
      reg_idx_t   rt;
      logic [2:0] unused;
   } r_fmt_t;

   // Immediate format, also loads, stores and branches
   typedef struct packed {
      opcode_e     opcode;
      reg_idx_t    rd;
      reg_idx_t    rs;
      logic [5:0]  imm;
   } i_fmt_t;

   // One word, two views
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

   // NOP opcode in the top nibble, all fields zero
   localparam logic [data_w-1:0] nop_word = 16'h1000;

endpackage

`default_nettype wire
